// File: kickerPkg.sv
package kickerPkg;

	// ==================================================
	// averaging window
	// ==================================================

	// log2 of the window depth
	// mean is the running sum shifted right by this
	localparam int windowLog2 = 5;

	// samples per moving average
	localparam int windowDepth = 1 << windowLog2;

	// ==================================================
	// data widths
	// ==================================================

	// rise-to-rise period in clock cycles
	typedef logic [18:0] periodT;

	// pulser elapsed time taken at a beam falling edge
	typedef logic [17:0] offsetT;

	// running sum of one window
	// wide enough for 32 full-scale periods
	typedef logic [23:0] sumT;

	// kicker on/off ratio in pulser cycles
	typedef logic [6:0] ratioT;

	// ==================================================
	// kicker sequencer states
	// ==================================================

	// idle right after reset
	// waitAverages until all three windows are full
	// faultState is left only through reset
	typedef enum logic [2:0]
	{
		idleState,
		waitAveragesState,
		kickerOffState,
		kickerOnState,
		faultState
	} kickerStateT;

endpackage

// File: edgeIntervalTimer.sv
`timescale 1ns/1ps

module edgeIntervalTimer
(
	input  logic              CLOCK_80MHZ,
	input  logic              resetButton,
	input  logic              rawSignal,
	output logic              riseStrobe,
	output logic              fallStrobe,
	output logic              periodValid,
	output kickerPkg::periodT period,
	output kickerPkg::offsetT elapsed
);

	localparam int periodWidth = $bits(kickerPkg::periodT);
	localparam int offsetWidth = $bits(kickerPkg::offsetT);
	localparam kickerPkg::periodT countMax = '1;

	// synchronizer and edge history
	logic syncStage0;
	logic syncStage1;
	logic syncPrev;

	logic riseDetect;
	logic fallDetect;

	// no period until a first rise has been seen
	logic seenRise;

	// cycles since the last rise
	kickerPkg::periodT count;
	kickerPkg::periodT countPlusOne;

	// ==================================================
	// input synchronizer
	// ==================================================

	// two flops for metastability, third for edge history
	always_ff @(posedge CLOCK_80MHZ)
	begin
		syncStage0 <= rawSignal;
		syncStage1 <= syncStage0;
		syncPrev <= syncStage1;
	end

	assign riseDetect = syncStage1 & ~syncPrev;
	assign fallDetect = ~syncStage1 & syncPrev;

	// saturating next count
	assign countPlusOne = (count == countMax) ? countMax : count + kickerPkg::periodT'(1);

	// ==================================================
	// strobes and interval counter
	// ==================================================

	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
		begin
			riseStrobe <= 1'b0;
			fallStrobe <= 1'b0;
			periodValid <= 1'b0;
			seenRise <= 1'b0;
			count <= '0;
		end
		else
		begin
			// strobes land 3 edges after the raw change
			riseStrobe <= riseDetect;
			fallStrobe <= fallDetect;
			// first rise after reset has no previous rise to measure from
			periodValid <= riseDetect & seenRise;
			if (riseDetect)
				seenRise <= 1'b1;
			// restart so elapsed reads 1 right after the strobe
			if (riseStrobe)
				count <= kickerPkg::periodT'(1);
			else if (seenRise)
				count <= countPlusOne;
		end
	end

	// count here is one short of the finished period
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (riseDetect)
			period <= countPlusOne;
	end

	// clamp to the narrower offset width
	assign elapsed = (|count[periodWidth-1:offsetWidth]) ? '1 : count[offsetWidth-1:0];

	// a synchronized level cannot rise and fall in one cycle
	strobesExclusive: assert property (@(posedge CLOCK_80MHZ) disable iff (resetButton)
		!(riseStrobe && fallStrobe))
		else $error("rise and fall strobes high together");

endmodule

// File: slidingWindowSum.sv
`timescale 1ns/1ps

module slidingWindowSum
#(
	parameter type sampleT = kickerPkg::periodT,
	// power of two so the mean is a plain shift
	parameter int depth = kickerPkg::windowDepth
)
(
	input  logic            CLOCK_80MHZ,
	input  logic            resetButton,
	input  logic            push,
	input  sampleT          sample,
	output kickerPkg::sumT  sum,
	output sampleT          mean,
	output logic            full
);

	localparam int indexWidth = $clog2(depth);
	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(depth - 1);

	// circular sample store
	sampleT store [depth];

	// next slot to write, also counts pushes until full
	logic [indexWidth-1:0] writeIndex;
	logic [indexWidth-1:0] newestIndex;

	// new and evicted samples at sum width
	kickerPkg::sumT sampleWide;
	kickerPkg::sumT evictedWide;

	assign newestIndex = writeIndex - indexWidth'(1);
	assign sampleWide = kickerPkg::sumT'(sample);

	// nothing to evict until the window has wrapped once
	assign evictedWide = full ? kickerPkg::sumT'(store[writeIndex]) : '0;

	// ==================================================
	// sample store
	// ==================================================

	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (push)
			store[writeIndex] <= sample;
	end

	// ==================================================
	// running sum and fill tracking
	// ==================================================

	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
		begin
			sum <= '0;
			writeIndex <= '0;
			full <= 1'b0;
		end
		else if (push)
		begin
			// add newest, drop the one being overwritten
			sum <= sum + sampleWide - evictedWide;
			// wraps naturally at a power-of-two depth
			writeIndex <= writeIndex + indexWidth'(1);
			// set on the last slot of the first pass
			if (writeIndex == lastIndex)
				full <= 1'b1;
		end
	end

	// divide by depth
	assign mean = sampleT'(sum >> indexWidth);

	// samples are unsigned so the sum holds at least the newest one
	sumCoversNewest: assert property (@(posedge CLOCK_80MHZ) disable iff (resetButton)
		full |-> sum >= kickerPkg::sumT'(store[newestIndex]))
		else $error("window sum below newest sample");

endmodule

// File: kickerSequencer.sv
`timescale 1ns/1ps

module kickerSequencer
(
	input  logic              CLOCK_80MHZ,
	input  logic              resetButton,
	input  logic              averagesReady,
	input  kickerPkg::offsetT offsetMean,
	input  kickerPkg::offsetT pulserElapsed,
	input  logic              pulserRise,
	input  logic              beamRise,
	input  logic              beamOn,
	input  kickerPkg::ratioT  onRatio,
	input  kickerPkg::ratioT  offRatio,
	output logic              kickTrigger,
	output logic              fault
);

	kickerPkg::kickerStateT state;
	kickerPkg::kickerStateT nextState;

	// once per pulser period at the averaged beam phase
	logic phaseMatch;

	// matches counted in the current on or off interval
	kickerPkg::ratioT matchCount;

	// beam rises minus pulser rises
	logic signed [2:0] balance;
	logic balanceFault;

	assign phaseMatch = averagesReady && (pulserElapsed == offsetMean);

	// trains more than one cycle apart
	assign balanceFault = (balance > 3'sd1) || (balance < -3'sd1);

	// ==================================================
	// lockstep monitor
	// ==================================================

	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
			balance <= '0;
		// both rising together leaves the balance alone
		else if (beamRise && !pulserRise && balance != 3'sd3)
			balance <= balance + 3'sd1;
		else if (pulserRise && !beamRise && balance != -3'sd4)
			balance <= balance - 3'sd1;
	end

	// ==================================================
	// next state
	// ==================================================

	always_comb
	begin
		nextState = state;
		case (state)
			kickerPkg::idleState:
				nextState = kickerPkg::waitAveragesState;
			kickerPkg::waitAveragesState:
			begin
				if (averagesReady)
					nextState = kickerPkg::kickerOffState;
			end
			kickerPkg::kickerOffState:
			begin
				// kicks only start while beam is on
				if (phaseMatch && matchCount == offRatio && beamOn)
					nextState = kickerPkg::kickerOnState;
			end
			kickerPkg::kickerOnState:
			begin
				// an interval already on always runs to its end
				if (phaseMatch && matchCount == onRatio)
					nextState = kickerPkg::kickerOffState;
			end
			kickerPkg::faultState:
				nextState = kickerPkg::faultState;
			default:
				nextState = kickerPkg::idleState;
		endcase
		// drift overrides every other transition
		if (balanceFault)
			nextState = kickerPkg::faultState;
	end

	// ==================================================
	// state, ratio counter and trigger
	// ==================================================

	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
		begin
			state <= kickerPkg::idleState;
			matchCount <= kickerPkg::ratioT'(1);
			kickTrigger <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// registered from next state so it moves with the state
			kickTrigger <= (nextState == kickerPkg::kickerOnState);
			if (nextState != state)
				matchCount <= kickerPkg::ratioT'(1);
			else if (phaseMatch)
			begin
				// off interval done with beam off, start a new one
				if (state == kickerPkg::kickerOffState && matchCount == offRatio)
					matchCount <= kickerPkg::ratioT'(1);
				else if (state == kickerPkg::kickerOffState || state == kickerPkg::kickerOnState)
					matchCount <= matchCount + kickerPkg::ratioT'(1);
			end
		end
	end

	assign fault = (state == kickerPkg::faultState);

	// trigger is forced low on the same edge that enters fault
	noKickInFault: assert property (@(posedge CLOCK_80MHZ)
		state == kickerPkg::faultState |-> !kickTrigger)
		else $error("kick trigger high while in fault");

	// only reset leaves the fault state
	faultSticky: assert property (@(posedge CLOCK_80MHZ)
		(state == kickerPkg::faultState && !resetButton) |=> state == kickerPkg::faultState)
		else $error("fault state left without reset");

endmodule

// File: kickerTrigger.sv
`timescale 1ns/1ps

module kickerTrigger
#(
	// window depth is 2**depthLog2
	parameter int depthLog2 = kickerPkg::windowLog2
)
(
	input  logic              CLOCK_80MHZ,
	input  logic              resetButton,
	input  logic              beamSignal,
	input  logic              pulserSignal,
	input  logic              beamOn,
	input  kickerPkg::ratioT  onRatio,
	input  kickerPkg::ratioT  offRatio,
	output logic              kickTrigger,
	output logic              fault,
	output logic              averagesReady,
	output kickerPkg::periodT meanBeamPeriod,
	output kickerPkg::periodT meanPulserPeriod
);

	localparam int windowSize = 1 << depthLog2;

	// beam train timing
	logic beamRise;
	logic beamFall;
	logic beamPeriodValid;
	kickerPkg::periodT beamPeriod;

	// pulser train timing
	logic pulserRise;
	logic pulserPeriodValid;
	kickerPkg::periodT pulserPeriod;
	kickerPkg::offsetT pulserElapsed;

	// offset sample only once the pulser has a reference rise
	logic offsetPush;

	logic beamFull;
	logic pulserFull;
	logic offsetFull;
	kickerPkg::offsetT offsetMean;

	// ==================================================
	// edge timers
	// ==================================================

	edgeIntervalTimer beamTimer
	(
		.CLOCK_80MHZ (CLOCK_80MHZ),
		.resetButton (resetButton),
		.rawSignal   (beamSignal),
		.riseStrobe  (beamRise),
		.fallStrobe  (beamFall),
		.periodValid (beamPeriodValid),
		.period      (beamPeriod),
		.elapsed     ()
	);

	edgeIntervalTimer pulserTimer
	(
		.CLOCK_80MHZ (CLOCK_80MHZ),
		.resetButton (resetButton),
		.rawSignal   (pulserSignal),
		.riseStrobe  (pulserRise),
		.fallStrobe  (),
		.periodValid (pulserPeriodValid),
		.period      (pulserPeriod),
		.elapsed     (pulserElapsed)
	);

	// elapsed stays 0 until the first pulser rise
	assign offsetPush = beamFall && (pulserElapsed != '0);

	// ==================================================
	// moving averages
	// ==================================================

	slidingWindowSum #(.sampleT(kickerPkg::periodT), .depth(windowSize)) beamWindow
	(
		.CLOCK_80MHZ (CLOCK_80MHZ),
		.resetButton (resetButton),
		.push        (beamPeriodValid),
		.sample      (beamPeriod),
		.sum         (),
		.mean        (meanBeamPeriod),
		.full        (beamFull)
	);

	slidingWindowSum #(.sampleT(kickerPkg::periodT), .depth(windowSize)) pulserWindow
	(
		.CLOCK_80MHZ (CLOCK_80MHZ),
		.resetButton (resetButton),
		.push        (pulserPeriodValid),
		.sample      (pulserPeriod),
		.sum         (),
		.mean        (meanPulserPeriod),
		.full        (pulserFull)
	);

	// phase of the beam fall within the pulser cycle
	slidingWindowSum #(.sampleT(kickerPkg::offsetT), .depth(windowSize)) offsetWindow
	(
		.CLOCK_80MHZ (CLOCK_80MHZ),
		.resetButton (resetButton),
		.push        (offsetPush),
		.sample      (pulserElapsed),
		.sum         (),
		.mean        (offsetMean),
		.full        (offsetFull)
	);

	assign averagesReady = beamFull & pulserFull & offsetFull;

	// ==================================================
	// kicker sequencing
	// ==================================================

	kickerSequencer sequencer
	(
		.CLOCK_80MHZ   (CLOCK_80MHZ),
		.resetButton   (resetButton),
		.averagesReady (averagesReady),
		.offsetMean    (offsetMean),
		.pulserElapsed (pulserElapsed),
		.pulserRise    (pulserRise),
		.beamRise      (beamRise),
		.beamOn        (beamOn),
		.onRatio       (onRatio),
		.offRatio      (offRatio),
		.kickTrigger   (kickTrigger),
		.fault         (fault)
	);

endmodule

// File: kickerTriggerTb.sv
`timescale 1ns/1ps

module kickerTriggerTb;

	// train timing in clock cycles
	localparam int period = 40;
	localparam int pulserHigh = 10;
	localparam int beamLag = 12;
	localparam int beamHigh = 16;

	// 60 pulser periods per phase, 4 phases, 20 ns clock, plus margin
	localparam int watchdogNs = 60 * 4 * period * 20 + 20000;

	logic CLOCK_80MHZ;
	logic resetButton;
	logic beamSignal;
	logic pulserSignal;
	logic beamOn;
	kickerPkg::ratioT onRatio;
	kickerPkg::ratioT offRatio;
	logic kickTrigger;
	logic fault;
	logic averagesReady;
	kickerPkg::periodT meanBeamPeriod;
	kickerPkg::periodT meanPulserPeriod;

	integer seed;
	int errorCount;

	// train generator state
	logic trainsRun;
	logic pulserRun;
	logic pulserMissing;
	int trainPhase;
	int completedPeriods;

	// kick interval tracking, settled 2 ns after the edge
	logic ratioCheck;
	logic kickPrev;
	logic fallSeen;
	int runLength;
	int lastLength;
	int stopCycles;

	kickerTrigger #(.depthLog2(kickerPkg::windowLog2)) uut
	(
		.CLOCK_80MHZ      (CLOCK_80MHZ),
		.resetButton      (resetButton),
		.beamSignal       (beamSignal),
		.pulserSignal     (pulserSignal),
		.beamOn           (beamOn),
		.onRatio          (onRatio),
		.offRatio         (offRatio),
		.kickTrigger      (kickTrigger),
		.fault            (fault),
		.averagesReady    (averagesReady),
		.meanBeamPeriod   (meanBeamPeriod),
		.meanPulserPeriod (meanPulserPeriod)
	);

	initial
		CLOCK_80MHZ = 1'b0;

	always #10 CLOCK_80MHZ = ~CLOCK_80MHZ;

	// ==================================================
	// stimulus trains
	// ==================================================

	// one cycle of both trains, beam lags the pulser
	task automatic driveTrains();
		begin
			if (!trainsRun)
			begin
				trainPhase = 0;
				completedPeriods = 0;
				pulserMissing = 1'b0;
				pulserSignal = 1'b0;
				beamSignal = 1'b0;
			end
			else
			begin
				// a stopped pulser counts from its first missing rise
				if (trainPhase == 0 && !pulserRun)
					pulserMissing = 1'b1;
				pulserSignal = pulserRun && (trainPhase < pulserHigh);
				beamSignal = (trainPhase >= beamLag) && (trainPhase < beamLag + beamHigh);
				if (trainPhase == period - 1)
				begin
					trainPhase = 0;
					completedPeriods++;
				end
				else
					trainPhase++;
			end
		end
	endtask

	always @(posedge CLOCK_80MHZ)
	begin
		#1;
		driveTrains();
	end

	// length of each kick level and time since the pulser stopped
	always @(posedge CLOCK_80MHZ)
	begin
		#2;
		if (resetButton)
		begin
			runLength = 0;
			fallSeen = 1'b0;
		end
		else if (kickTrigger != kickPrev)
		begin
			lastLength = runLength;
			runLength = 1;
			if (!kickTrigger)
				fallSeen = 1'b1;
		end
		else
			runLength++;
		kickPrev = kickTrigger;
		if (!pulserMissing)
			stopCycles = 0;
		else if (stopCycles < 100000)
			stopCycles++;
	end

	task automatic startTrains();
		begin
			@(negedge CLOCK_80MHZ);
			pulserRun = 1'b1;
			trainsRun = 1'b1;
		end
	endtask

	task automatic waitKicks(input int count);
		begin
			repeat (count) @(posedge kickTrigger);
		end
	endtask

	// intervals are checked again from the first rise under stable inputs
	task automatic armRatioCheck();
		begin
			@(posedge kickTrigger);
			@(negedge CLOCK_80MHZ);
			#1;
			ratioCheck = 1'b1;
		end
	endtask

	// ==================================================
	// checks, sampled at the falling clock edge
	// ==================================================

	readyInTime: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		(trainsRun && completedPeriods >= 33) |-> averagesReady)
		else
		begin
			errorCount++;
			$display("averages not ready after 33 periods of both trains");
		end

	meanValues: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		averagesReady |-> (meanBeamPeriod == kickerPkg::periodT'(period)
			&& meanPulserPeriod == kickerPkg::periodT'(period)))
		else
		begin
			errorCount++;
			$display("[ERROR] meanValues: expected %0d, actual beam %0d pulser %0d",
				period, meanBeamPeriod, meanPulserPeriod);
		end

	earlyKick: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		kickTrigger |-> $past(averagesReady))
		else
		begin
			errorCount++;
			$display("kick trigger high before the averages were ready");
		end

	highLength: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		(ratioCheck && $fell(kickTrigger)) |-> lastLength == int'(onRatio) * period)
		else
		begin
			errorCount++;
			$display("[ERROR] highLength: expected %0d, actual %0d",
				int'(onRatio) * period, lastLength);
		end

	lowLength: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		(ratioCheck && fallSeen && $rose(kickTrigger)) |->
			lastLength == int'(offRatio) * period)
		else
		begin
			errorCount++;
			$display("[ERROR] lowLength: expected %0d, actual %0d",
				int'(offRatio) * period, lastLength);
		end

	// a rise comes from the edge that saw beamOn one cycle back
	beamGating: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		$rose(kickTrigger) |-> $past(beamOn))
		else
		begin
			errorCount++;
			$display("kick trigger rose while beamOn was low");
		end

	faultInTime: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		(stopCycles == 2 * period + 4) |-> fault)
		else
		begin
			errorCount++;
			$display("fault missing two beam periods after the pulser stopped");
		end

	kickLowInFault: assert property (@(negedge CLOCK_80MHZ) disable iff (resetButton)
		fault |-> !kickTrigger)
		else
		begin
			errorCount++;
			$display("kick trigger high while fault is set");
		end

	faultHolds: assert property (@(negedge CLOCK_80MHZ)
		(fault && !resetButton) |=> fault)
		else
		begin
			errorCount++;
			$display("fault cleared without a reset");
		end

	resetClears: assert property (@(negedge CLOCK_80MHZ)
		resetButton |=> (!fault && !kickTrigger && !averagesReady))
		else
		begin
			errorCount++;
			$display("[ERROR] resetClears: expected fault/kick/ready 000, actual %b%b%b",
				fault, kickTrigger, averagesReady);
		end

	// ==================================================
	// test sequence
	// ==================================================

	initial
	begin
		seed = 32'ha192a949;
		errorCount = 0;
		resetButton = 1'b1;
		beamSignal = 1'b0;
		pulserSignal = 1'b0;
		beamOn = 1'b1;
		onRatio = kickerPkg::ratioT'(1);
		offRatio = kickerPkg::ratioT'(2);
		trainsRun = 1'b0;
		pulserRun = 1'b1;
		pulserMissing = 1'b0;
		trainPhase = 0;
		completedPeriods = 0;
		ratioCheck = 1'b1;
		kickPrev = 1'b0;
		fallSeen = 1'b0;
		runLength = 0;
		lastLength = 0;
		stopCycles = 0;
		repeat (4) @(posedge CLOCK_80MHZ);
		#1;
		resetButton = 1'b0;

		// averages, then default 1:2 ratio
		startTrains();
		wait (averagesReady);
		waitKicks(3);

		// random ratios, changed just after a rise so the count is 1
		@(posedge CLOCK_80MHZ);
		#1;
		ratioCheck = 1'b0;
		onRatio = kickerPkg::ratioT'(1 + ($random(seed) & 3));
		offRatio = kickerPkg::ratioT'(1 + ($random(seed) & 3));
		armRatioCheck();
		waitKicks(2);

		// beam off while a kick is on, the kick still ends on time
		@(posedge CLOCK_80MHZ);
		#1;
		beamOn = 1'b0;
		@(negedge kickTrigger);
		@(negedge CLOCK_80MHZ);
		#1;
		ratioCheck = 1'b0;
		repeat (8 * period) @(posedge CLOCK_80MHZ);
		#1;
		beamOn = 1'b1;
		armRatioCheck();
		waitKicks(1);

		// pulser stops during a kick, beam keeps running
		ratioCheck = 1'b0;
		@(negedge CLOCK_80MHZ);
		pulserRun = 1'b0;
		wait (fault);
		repeat (3 * period) @(posedge CLOCK_80MHZ);

		// reset press clears the fault, then a fresh start
		@(negedge CLOCK_80MHZ);
		trainsRun = 1'b0;
		@(posedge CLOCK_80MHZ);
		#1;
		resetButton = 1'b1;
		repeat (2) @(posedge CLOCK_80MHZ);
		#1;
		resetButton = 1'b0;
		startTrains();
		wait (completedPeriods >= 34);
		repeat (2) @(posedge CLOCK_80MHZ);

		$display("run finished with %0d errors", errorCount);
		if (errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(watchdogNs);
		$display("watchdog expired before the test sequence finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src.f
kickerPkg.sv
edgeIntervalTimer.sv
slidingWindowSum.sv
kickerSequencer.sv
kickerTrigger.sv
kickerTriggerTb.sv

// File: runSim.sh
#!/bin/bash
# build the kicker trigger testbench with Verilator and run it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module kickerTriggerTb \
	-f src.f -o simKicker \
	&& ./obj_dir/simKicker > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log \
	|| { echo "simulation reported failure"; exit 1; }
